/* cipher_data_pkg.sv */
// Datapath widths and types of the cipher core
// Byte, state, full key, round counter and key length
package cipher_data_pkg;

  // Number of bytes in the state and in the full key
  localparam int unsigned StateBytes = 4;
  localparam int unsigned KeyBytes   = 8;

  // One data byte
  typedef logic [7:0] byte_t;

  // Cipher state, byte 0 in the least significant position
  typedef logic [8*StateBytes-1:0] state_t;

  // Full key register contents
  typedef logic [8*KeyBytes-1:0] key_t;

  // Round counter, wide enough for 14 rounds
  typedef logic [3:0] rnd_ctr_t;

  // Key length selection
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

endpackage

/* cipher_ctrl_pkg.sv */
// Control encodings of the cipher core
// FSM states and the datapath selector enums
package cipher_ctrl_pkg;

  // Round sequencing FSM
  typedef enum logic [2:0] {
    CTRL_IDLE     = 3'd0,
    CTRL_INIT     = 3'd1,
    CTRL_ROUND    = 3'd2,
    CTRL_FINISH   = 3'd3,
    CTRL_CLEAR_S  = 3'd4,
    CTRL_CLEAR_KD = 3'd5,
    CTRL_ERROR    = 3'd6
  } ctrl_state_e;

  // Next value of the state register
  typedef enum logic [1:0] {STATE_INIT, STATE_ROUND, STATE_CLEAR} state_sel_e;

  // Operand fed into add-round-key
  typedef enum logic [1:0] {ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL} add_rk_sel_e;

  // Next value of the full key register
  typedef enum logic [1:0] {KEY_FULL_INIT, KEY_FULL_EXPAND, KEY_FULL_CLEAR} key_full_sel_e;

  // Key bytes that form the round key
  typedef enum logic [1:0] {
    KEY_WORDS_ZERO,
    KEY_WORDS_0123,
    KEY_WORDS_2345,
    KEY_WORDS_4567
  } key_words_sel_e;

endpackage

/* cipher_state_if.sv */
// Control and handshake signals between the FSM and the state path
interface cipher_state_if import cipher_ctrl_pkg::*; ();

  // State register control
  state_sel_e  state_sel;
  logic        state_we;
  add_rk_sel_e add_rk_sel;

  // Substitution unit handshake
  logic        sub_bytes_en;
  logic        sub_bytes_out_req;
  logic        sub_bytes_out_ack;

  modport ctrl (
    output state_sel, state_we, add_rk_sel,
    output sub_bytes_en, sub_bytes_out_ack,
    input  sub_bytes_out_req
  );

  modport dp (
    input  state_sel, state_we, add_rk_sel,
    input  sub_bytes_en, sub_bytes_out_ack,
    output sub_bytes_out_req
  );

endinterface

/* cipher_key_if.sv */
// Control signals between the FSM and the key path
interface cipher_key_if import cipher_data_pkg::*, cipher_ctrl_pkg::*; ();

  // Full key register control
  key_full_sel_e  key_full_sel;
  logic           key_full_we;
  logic           key_expand_en;

  // Round key selection and expansion constant
  key_words_sel_e key_words_sel;
  rnd_ctr_t       rnd_ctr;

  modport ctrl (
    output key_full_sel, key_full_we, key_expand_en, key_words_sel, rnd_ctr
  );

  modport dp (
    input  key_full_sel, key_full_we, key_expand_en, key_words_sel, rnd_ctr
  );

endinterface

/* cipher_sub_bytes.sv */
// Multi-cycle byte substitution with request/acknowledge output
module cipher_sub_bytes import cipher_data_pkg::*; #(
  parameter int unsigned SubCycles = 4
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   en_i,
  input  state_t state_i,
  input  logic   out_ack_i,
  output logic   out_req_o,
  output state_t data_o
);

  localparam int unsigned     CntW    = (SubCycles > 1) ? $clog2(SubCycles) : 1;
  localparam logic [CntW-1:0] CntLast = CntW'(SubCycles - 1);

  // Stand-in S-box
  function automatic byte_t sbox(byte_t b);
    return {b[6:0], b[7]} ^ {b[3:0], b[7:4]} ^ 8'h63;
  endfunction

  state_t          in_q;
  logic [CntW-1:0] cnt_q;
  logic            req_q;
  logic            capture;

  // Take the operand on the first cycle of a new run
  assign capture = en_i & ~req_q & (cnt_q == '0);

  always_ff @(posedge clk_i) begin : reg_in
    if (capture) begin
      in_q <= state_i;
    end
  end

  // Latency counter, request held until acknowledged
  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
      req_q <= 1'b0;
    end else if (req_q) begin
      if (out_ack_i) begin
        req_q <= 1'b0;
      end
    end else if (en_i) begin
      if (cnt_q == CntLast) begin
        req_q <= 1'b1;
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else begin
      // Abort a run when the enable drops
      cnt_q <= '0;
    end
  end

  assign out_req_o = req_q;

  always_comb begin : sub_out
    for (int i = 0; i < StateBytes; i++) begin
      data_o[8*i +: 8] = sbox(in_q[8*i +: 8]);
    end
  end

endmodule

/* cipher_state_path.sv */
// State register, mix step and add-round-key of the cipher core
module cipher_state_path import cipher_data_pkg::*, cipher_ctrl_pkg::*; #(
  parameter int unsigned SubCycles = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  state_t            data_i,
  input  state_t            round_key_i,
  cipher_state_if.dp        state_if,
  output state_t            data_o
);

  state_t state_q, state_d;
  state_t sub_out, mix_out, add_rk_in, add_rk_out;

  cipher_sub_bytes #(
    .SubCycles (SubCycles)
  ) i_sub_bytes (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .en_i      (state_if.sub_bytes_en),
    .state_i   (state_q),
    .out_ack_i (state_if.sub_bytes_out_ack),
    .out_req_o (state_if.sub_bytes_out_req),
    .data_o    (sub_out)
  );

  // Each byte mixes with the rotated next byte
  always_comb begin : mix_step
    byte_t nb;
    for (int i = 0; i < StateBytes; i++) begin
      nb = sub_out[8*((i+1)%StateBytes) +: 8];
      mix_out[8*i +: 8] = sub_out[8*i +: 8] ^ {nb[6:0], nb[7]};
    end
  end

  // Add-round-key operand
  always_comb begin : add_rk_mux
    case (state_if.add_rk_sel)
      ADD_RK_INIT:  add_rk_in = state_q;
      ADD_RK_ROUND: add_rk_in = mix_out;
      ADD_RK_FINAL: add_rk_in = sub_out;
      default:      add_rk_in = '0;
    endcase
  end

  assign add_rk_out = add_rk_in ^ round_key_i;

  always_comb begin : state_mux
    case (state_if.state_sel)
      STATE_INIT:  state_d = data_i;
      STATE_ROUND: state_d = add_rk_out;
      default:     state_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_state
    if (!rst_ni) begin
      state_q <= '0;
    end else if (state_if.state_we) begin
      state_q <= state_d;
    end
  end

  assign data_o = add_rk_out;

endmodule

/* cipher_key_path.sv */
// Full key register, key expansion and round key selection
module cipher_key_path import cipher_data_pkg::*, cipher_ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  key_t            key_i,
  cipher_key_if.dp        key_if,
  output state_t          round_key_o
);

  key_t key_q, key_d, key_expanded;

  // Rotate up by one byte, then fold the round constant into byte 0
  assign key_expanded = {key_q[8*KeyBytes-9:0], key_q[8*KeyBytes-1 -: 8]}
                      ^ key_t'({4'd0, key_if.rnd_ctr});

  always_comb begin : key_full_mux
    case (key_if.key_full_sel)
      KEY_FULL_INIT:   key_d = key_i;
      KEY_FULL_EXPAND: key_d = key_if.key_expand_en ? key_expanded : key_q;
      default:         key_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_key_full
    if (!rst_ni) begin
      key_q <= '0;
    end else if (key_if.key_full_we) begin
      key_q <= key_d;
    end
  end

  // Round key word window
  always_comb begin : key_words_mux
    case (key_if.key_words_sel)
      KEY_WORDS_0123: round_key_o = key_q[31:0];
      KEY_WORDS_2345: round_key_o = key_q[47:16];
      KEY_WORDS_4567: round_key_o = key_q[63:32];
      default:        round_key_o = '0;
    endcase
  end

endmodule

/* cipher_control_fsm.sv */
// Round sequencing FSM of the cipher core
// Round counter, round count and clear command registers
module cipher_control_fsm import cipher_data_pkg::*, cipher_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  // Input handshake and commands
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  logic         crypt_i,
  input  logic         key_clear_i,
  input  logic         data_out_clear_i,
  input  key_len_e     key_len_i,

  // Output handshake
  output logic         out_valid_o,
  input  logic         out_ready_i,

  // Alerts
  input  logic         alert_fatal_i,
  output logic         alert_o,

  // Datapath control
  cipher_state_if.ctrl state_if,
  cipher_key_if.ctrl   key_if
);

  ctrl_state_e    ctrl_ns, ctrl_cs;
  rnd_ctr_t       rnd_ctr_d, rnd_ctr_q;
  rnd_ctr_t       num_rounds_d, num_rounds_q;
  rnd_ctr_t       num_rounds_regular;
  rnd_ctr_t       num_rounds_len;
  logic           key_clear_d, key_clear_q;
  logic           data_out_clear_d, data_out_clear_q;
  key_words_sel_e key_words_rnd;

  // Last regular round is one before the final round
  assign num_rounds_regular = num_rounds_q - 4'd1;

  // Round count and round key words follow the key length
  always_comb begin : key_len_decode
    case (key_len_i)
      AES_128: begin
        num_rounds_len = 4'd10;
        key_words_rnd  = KEY_WORDS_0123;
      end
      AES_192: begin
        num_rounds_len = 4'd12;
        key_words_rnd  = KEY_WORDS_2345;
      end
      AES_256: begin
        num_rounds_len = 4'd14;
        key_words_rnd  = KEY_WORDS_4567;
      end
      default: begin
        num_rounds_len = 4'd14;
        key_words_rnd  = KEY_WORDS_ZERO;
      end
    endcase
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : ctrl_fsm
    // Handshakes and alert
    in_ready_o                 = 1'b0;
    out_valid_o                = 1'b0;
    alert_o                    = 1'b0;

    // State path
    state_if.state_sel         = STATE_ROUND;
    state_if.state_we          = 1'b0;
    state_if.add_rk_sel        = ADD_RK_ROUND;
    state_if.sub_bytes_en      = 1'b0;
    state_if.sub_bytes_out_ack = 1'b0;

    // Key path
    key_if.key_full_sel        = KEY_FULL_EXPAND;
    key_if.key_full_we         = 1'b0;
    key_if.key_expand_en       = 1'b0;
    key_if.key_words_sel       = KEY_WORDS_ZERO;

    // Registers hold by default
    ctrl_ns                    = ctrl_cs;
    rnd_ctr_d                  = rnd_ctr_q;
    num_rounds_d               = num_rounds_q;
    key_clear_d                = key_clear_q;
    data_out_clear_d           = data_out_clear_q;

    case (ctrl_cs)
      CTRL_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          if (key_clear_i || data_out_clear_i) begin
            key_clear_d      = key_clear_i;
            data_out_clear_d = data_out_clear_i;
            // State goes to zero first when data output is cleared
            ctrl_ns          = data_out_clear_i ? CTRL_CLEAR_S : CTRL_CLEAR_KD;
          end else if (crypt_i) begin
            // Load data and key, start the round count
            state_if.state_sel  = STATE_INIT;
            state_if.state_we   = 1'b1;
            key_if.key_full_sel = KEY_FULL_INIT;
            key_if.key_full_we  = 1'b1;
            num_rounds_d        = num_rounds_len;
            rnd_ctr_d           = '0;
            ctrl_ns             = CTRL_INIT;
          end else begin
            // Handshake without any command
            ctrl_ns = CTRL_ERROR;
          end
        end
      end

      CTRL_INIT: begin
        // Initial add-round-key always on bytes 0 to 3
        state_if.add_rk_sel  = ADD_RK_INIT;
        state_if.state_we    = 1'b1;
        key_if.key_words_sel = KEY_WORDS_0123;
        key_if.key_expand_en = 1'b1;
        key_if.key_full_we   = 1'b1;
        rnd_ctr_d            = rnd_ctr_q + 4'd1;
        ctrl_ns              = CTRL_ROUND;
      end

      CTRL_ROUND: begin
        state_if.sub_bytes_en = 1'b1;
        key_if.key_words_sel  = key_words_rnd;
        key_if.key_expand_en  = 1'b1;
        // Advance once substitution is done
        if (state_if.sub_bytes_out_req) begin
          state_if.sub_bytes_out_ack = 1'b1;
          state_if.state_we          = 1'b1;
          key_if.key_full_we         = 1'b1;
          rnd_ctr_d                  = rnd_ctr_q + 4'd1;
          if (rnd_ctr_q >= num_rounds_regular) begin
            ctrl_ns = CTRL_FINISH;
          end
        end
      end

      CTRL_FINISH: begin
        // Final round skips the mix step
        state_if.sub_bytes_en = 1'b1;
        state_if.add_rk_sel   = ADD_RK_FINAL;
        key_if.key_words_sel  = key_words_rnd;
        // State is wiped on the output transfer
        state_if.state_sel    = STATE_CLEAR;
        out_valid_o           = state_if.sub_bytes_out_req;
        if (out_valid_o && out_ready_i) begin
          state_if.sub_bytes_out_ack = 1'b1;
          state_if.state_we          = 1'b1;
          ctrl_ns                    = CTRL_IDLE;
        end
      end

      CTRL_CLEAR_S: begin
        state_if.state_sel = STATE_CLEAR;
        state_if.state_we  = 1'b1;
        ctrl_ns            = CTRL_CLEAR_KD;
      end

      CTRL_CLEAR_KD: begin
        if (key_clear_q) begin
          key_if.key_full_sel = KEY_FULL_CLEAR;
          key_if.key_full_we  = 1'b1;
        end
        // Cleared state passes through with a zero round key
        if (data_out_clear_q) begin
          state_if.add_rk_sel  = ADD_RK_INIT;
          key_if.key_words_sel = KEY_WORDS_ZERO;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          key_clear_d      = 1'b0;
          data_out_clear_d = 1'b0;
          ctrl_ns          = CTRL_IDLE;
        end
      end

      CTRL_ERROR: begin
        // Terminal until reset
        alert_o = 1'b1;
      end

      default: begin
        ctrl_ns = CTRL_ERROR;
        alert_o = 1'b1;
      end
    endcase

    // Fatal alert wins over every state
    if (alert_fatal_i) begin
      ctrl_ns = CTRL_ERROR;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_fsm
    if (!rst_ni) begin
      ctrl_cs          <= CTRL_IDLE;
      rnd_ctr_q        <= '0;
      num_rounds_q     <= '0;
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else begin
      ctrl_cs          <= ctrl_ns;
      rnd_ctr_q        <= rnd_ctr_d;
      num_rounds_q     <= num_rounds_d;
      key_clear_q      <= key_clear_d;
      data_out_clear_q <= data_out_clear_d;
    end
  end

  // Expansion constant is the current round
  assign key_if.rnd_ctr = rnd_ctr_q;

endmodule

/* cipher_core.sv */
// Cipher core top level
// Control FSM, state path and key path behind plain ports
module cipher_core import cipher_data_pkg::*; #(
  parameter int unsigned SubCycles = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Input side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  logic     crypt_i,
  input  logic     key_clear_i,
  input  logic     data_out_clear_i,
  input  key_len_e key_len_i,
  input  state_t   data_i,
  input  key_t     key_i,

  // Output side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output state_t   data_o,

  // Alerts
  input  logic     alert_fatal_i,
  output logic     alert_o
);

  state_t round_key;

  cipher_state_if state_if ();
  cipher_key_if   key_if ();

  cipher_control_fsm i_control_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .crypt_i          (crypt_i),
    .key_clear_i      (key_clear_i),
    .data_out_clear_i (data_out_clear_i),
    .key_len_i        (key_len_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .alert_fatal_i    (alert_fatal_i),
    .alert_o          (alert_o),
    .state_if         (state_if.ctrl),
    .key_if           (key_if.ctrl)
  );

  cipher_state_path #(
    .SubCycles (SubCycles)
  ) i_state_path (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_i      (data_i),
    .round_key_i (round_key),
    .state_if    (state_if.dp),
    .data_o      (data_o)
  );

  cipher_key_path i_key_path (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_i       (key_i),
    .key_if      (key_if.dp),
    .round_key_o (round_key)
  );

endmodule

/* tb_cipher_core.sv */
// Random self-checking testbench of the cipher core
// Reference model, compare tasks and directed command tests
module tb_cipher_core import cipher_data_pkg::*; ();

  localparam int unsigned SubCycles = 4;
  // 60 random encryptions, 3 clears, 1 encryption after key clear, 2 error runs
  localparam int NumOps    = 66;
  localparam int MaxCycles = NumOps * (14 * (SubCycles + 2) + 20);

  logic     clk_i;
  logic     rst_ni;
  logic     in_valid_i;
  logic     in_ready_o;
  logic     crypt_i;
  logic     key_clear_i;
  logic     data_out_clear_i;
  key_len_e key_len_i;
  state_t   data_i;
  key_t     key_i;
  logic     out_valid_o;
  logic     out_ready_i;
  state_t   data_o;
  logic     alert_fatal_i;
  logic     alert_o;

  integer seed;
  int     errors       = 0;
  int     test_errors  = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     cycles       = 0;

  cipher_core #(
    .SubCycles (SubCycles)
  ) i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .crypt_i          (crypt_i),
    .key_clear_i      (key_clear_i),
    .data_out_clear_i (data_out_clear_i),
    .key_len_i        (key_len_i),
    .data_i           (data_i),
    .key_i            (key_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .data_o           (data_o),
    .alert_fatal_i    (alert_fatal_i),
    .alert_o          (alert_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Run limit from the worst case round count of every operation
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not complete within %0d cycles", MaxCycles);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic byte_t rotl8(byte_t b, int n);
    byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[(i + n) % 8] = b[i];
    end
    return r;
  endfunction

  function automatic state_t sub_state(state_t s);
    state_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = rotl8(s[8*i +: 8], 1) ^ rotl8(s[8*i +: 8], 4) ^ 8'h63;
    end
    return r;
  endfunction

  // Byte i picks up the rotated neighbour above it
  function automatic state_t mix_state(state_t s);
    state_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = s[8*i +: 8] ^ rotl8(s[8*((i + 1) % 4) +: 8], 1);
    end
    return r;
  endfunction

  function automatic key_t expand_key(key_t k, int c);
    key_t r;
    r      = {k[55:0], k[63:56]};
    r[7:0] = r[7:0] ^ 8'(c);
    return r;
  endfunction

  function automatic state_t select_round_key(key_t k, key_len_e len);
    case (len)
      AES_128: return k[31:0];
      AES_192: return k[47:16];
      default: return k[63:32];
    endcase
  endfunction

  task automatic model_encrypt(input state_t din, input key_t kin, input key_len_e len,
                               output state_t dout);
    state_t s;
    key_t   k;
    int     rounds;
    rounds = (len == AES_128) ? 10 : (len == AES_192) ? 12 : 14;
    // Initial add-round-key always on bytes 0 to 3
    s = din ^ kin[31:0];
    k = expand_key(kin, 0);
    for (int r = 1; r < rounds; r++) begin
      s = mix_state(sub_state(s)) ^ select_round_key(k, len);
      k = expand_key(k, r);
    end
    dout = sub_state(s) ^ select_round_key(k, len);
  endtask

  ////////////////////
  // Checks and bookkeeping
  ////////////////////

  task automatic check_state(input string name, input state_t exp_val, input state_t act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic open_test();
    test_errors = errors;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s (%0d checks wrong)", name, errors - test_errors);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic reset_dut();
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  // Holds the command inputs and drops in_valid_i after the transfer
  task automatic send_input(input logic crypt, input logic kclr, input logic dclr,
                            input key_len_e len, input state_t din, input key_t kin);
    crypt_i          = crypt;
    key_clear_i      = kclr;
    data_out_clear_i = dclr;
    key_len_i        = len;
    data_i           = din;
    key_i            = kin;
    in_valid_i       = 1'b1;
    while (!in_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Waits for the output transfer and checks that data holds while stalled
  task automatic collect_output(input string name, input logic check_data,
                                input state_t exp_val, input logic random_ready);
    logic   held;
    logic   done;
    state_t held_data;
    integer rnd;
    held = 1'b0;
    done = 1'b0;
    while (!done) begin
      if (held) begin
        check_flag({name, " valid held"}, 1'b1, out_valid_o);
        check_state({name, " data held"}, held_data, data_o);
      end
      rnd         = $random(seed);
      out_ready_i = random_ready ? rnd[0] : 1'b1;
      if (out_valid_o && out_ready_i) begin
        if (check_data) begin
          check_state(name, exp_val, data_o);
        end
        done = 1'b1;
      end else if (out_valid_o) begin
        held      = 1'b1;
        held_data = data_o;
      end
      @(negedge clk_i);
    end
    out_ready_i = 1'b0;
  endtask

  task automatic run_encrypt(input string name, input logic random_ready);
    state_t   din;
    key_t     kin;
    key_len_e len;
    state_t   exp_val;
    din = $random(seed);
    kin = {$random(seed), $random(seed)};
    case ($unsigned($random(seed)) % 3)
      0:       len = AES_128;
      1:       len = AES_192;
      default: len = AES_256;
    endcase
    model_encrypt(din, kin, len, exp_val);
    send_input(1'b1, 1'b0, 1'b0, len, din, kin);
    collect_output(name, 1'b1, exp_val, random_ready);
  endtask

  // ERROR must be sticky with both handshakes held low
  task automatic watch_error(input string name);
    repeat (20) begin
      check_flag({name, " alert_o"}, 1'b1, alert_o);
      check_flag({name, " in_ready_o"}, 1'b0, in_ready_o);
      check_flag({name, " out_valid_o"}, 1'b0, out_valid_o);
      @(negedge clk_i);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    seed             = 43;
    rst_ni           = 1'b0;
    in_valid_i       = 1'b0;
    crypt_i          = 1'b0;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
    key_len_i        = AES_128;
    data_i           = '0;
    key_i            = '0;
    out_ready_i      = 1'b0;
    alert_fatal_i    = 1'b0;
    reset_dut();

    open_test();
    check_flag("reset in_ready_o", 1'b1, in_ready_o);
    check_flag("reset out_valid_o", 1'b0, out_valid_o);
    check_flag("reset alert_o", 1'b0, alert_o);
    close_test("reset values");

    open_test();
    repeat (30) run_encrypt("encrypt ready high", 1'b0);
    close_test("random encryptions, out_ready_i high");

    open_test();
    repeat (30) run_encrypt("encrypt back-pressure", 1'b1);
    close_test("random encryptions, random out_ready_i");

    // Clear commands win over crypt_i
    open_test();
    send_input(1'b0, 1'b0, 1'b1, AES_128, 32'hdeadbeef, 64'h0123456789abcdef);
    collect_output("data-out clear", 1'b1, '0, 1'b1);
    check_flag("in_ready_o after data-out clear", 1'b1, in_ready_o);
    send_input(1'b1, 1'b1, 1'b1, AES_256, 32'h5a5a5a5a, 64'hfedcba9876543210);
    collect_output("data-out and key clear", 1'b1, '0, 1'b1);
    check_flag("in_ready_o after both clears", 1'b1, in_ready_o);
    close_test("data-out clear");

    open_test();
    send_input(1'b0, 1'b1, 1'b0, AES_192, 32'h13572468, 64'h1122334455667788);
    collect_output("key clear", 1'b0, '0, 1'b1);
    check_flag("in_ready_o after key clear", 1'b1, in_ready_o);
    run_encrypt("encrypt after key clear", 1'b1);
    close_test("key clear");

    open_test();
    send_input(1'b0, 1'b0, 1'b0, AES_128, '0, '0);
    watch_error("no command");
    close_test("handshake without command");

    open_test();
    reset_dut();
    check_flag("in_ready_o after reset", 1'b1, in_ready_o);
    send_input(1'b1, 1'b0, 1'b0, AES_256, 32'h0badcafe, 64'h0f1e2d3c4b5a6978);
    repeat (8) @(negedge clk_i);
    alert_fatal_i = 1'b1;
    @(negedge clk_i);
    alert_fatal_i = 1'b0;
    watch_error("fatal alert");
    reset_dut();
    check_flag("in_ready_o after final reset", 1'b1, in_ready_o);
    check_flag("alert_o after final reset", 1'b0, alert_o);
    close_test("fatal alert");

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb.f */
cipher_data_pkg.sv
cipher_ctrl_pkg.sv
cipher_state_if.sv
cipher_key_if.sv
cipher_sub_bytes.sv
cipher_state_path.sv
cipher_key_path.sv
cipher_control_fsm.sv
cipher_core.sv
tb_cipher_core.sv

/* Makefile */
SRCS = cipher_data_pkg.sv cipher_ctrl_pkg.sv cipher_state_if.sv cipher_key_if.sv \
       cipher_sub_bytes.sv cipher_state_path.sv cipher_key_path.sv \
       cipher_control_fsm.sv cipher_core.sv tb_cipher_core.sv

all: run

obj_dir/Vtb_cipher_core: tb.f $(SRCS)
	verilator --binary --timing -f tb.f --top-module tb_cipher_core -o Vtb_cipher_core

run: obj_dir/Vtb_cipher_core
	./obj_dir/Vtb_cipher_core | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
